/* src/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

    ////////////////////////////////////////
    // basic words
    ////////////////////////////////////////
    typedef logic [4:0]  regAddr_t;  // register number
    typedef logic [31:0] instr_t;    // raw instruction word

    // opcode field values
    localparam logic [5:0] OpAlu    = 6'd0;
    localparam logic [5:0] OpImm    = 6'd8;   // addi
    localparam logic [5:0] OpLoad   = 6'd35;  // lw
    localparam logic [5:0] OpStore  = 6'd43;  // sw
    localparam logic [5:0] OpBranch = 6'd4;   // beq
    localparam logic [5:0] OpJump   = 6'd2;   // j

    ////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        ClsAlu,     // writes rd
        ClsImm,     // writes rt
        ClsLoad,    // writes rt after memory
        ClsStore,
        ClsBranch,
        ClsJump,
        ClsNop
    } instrClass_t;

    typedef enum logic [2:0] {
        SlotIdle,
        SlotDecode,
        SlotExecute,
        SlotMem,
        SlotWbWait
    } slotState_t;

    // same codes as the PC mux select
    typedef enum logic [1:0] {
        PcNext   = 2'b00,
        PcBranch = 2'b01,
        PcJump   = 2'b10
    } pcSrc_t;

    typedef struct packed {
        instrClass_t cls;
        regAddr_t    dest;  // only meaningful for register writers
    } slotEntry_t;

    // issue blocked for this many cycles after a redirect
    localparam int unsigned JumpHold   = 2;
    localparam int unsigned BranchHold = 1;

endpackage

`default_nettype wire

/* src/poolIf.sv */
`default_nettype none

// status of every slot goes to the retire side,
// grants and the flush strobe come back
interface poolIf #(
    parameter int NumSlots = 5
);
    import ctrlPkg::*;

    slotState_t          slotState [NumSlots];  // one per slot
    slotEntry_t          slotEntry [NumSlots];
    logic [NumSlots-1:0] wbGrant;               // one-hot or zero
    logic                flush;                 // kill slots in decode

    modport pool (
        output slotState,
        output slotEntry,
        input  wbGrant,
        input  flush
    );

    modport retire (
        input  slotState,
        input  slotEntry,
        output wbGrant,
        output flush
    );

endinterface

`default_nettype wire

/* src/issueStage.sv */
`default_nettype none

module issueStage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire ctrlPkg::instr_t instr,
    input  wire                 instrValid,
    input  wire                 poolFull,
    input  wire                 memVisit,
    input  wire                 redirect,
    input  wire ctrlPkg::pcSrc_t redirectSrc,
    output logic                issue,
    output ctrlPkg::slotEntry_t entry,
    output logic                pcWrite,
    output ctrlPkg::pcSrc_t     pcSrc
);
    import ctrlPkg::*;

    logic [5:0]  opcode;
    instrClass_t cls;
    regAddr_t    dest;
    logic [1:0]  holdCnt;  // cycles left in the redirect window

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////
    assign opcode = instr[31:26];

    always_comb
    begin
        case (opcode)
            OpAlu:    cls = ClsAlu;
            OpImm:    cls = ClsImm;
            OpLoad:   cls = ClsLoad;
            OpStore:  cls = ClsStore;
            OpBranch: cls = ClsBranch;
            OpJump:   cls = ClsJump;
            default:  cls = ClsNop;
        endcase
    end

    always_comb
    begin
        case (cls)
            ClsAlu:          dest = instr[15:11];  // rd
            ClsImm, ClsLoad: dest = instr[20:16];  // rt
            default:         dest = '0;
        endcase
    end

    assign entry = '{cls: cls, dest: dest};

    ////////////////////////////////////////
    // issue and PC control
    ////////////////////////////////////////
    assign issue = instrValid && !poolFull && !memVisit && !redirect && (holdCnt == 2'd0);

    // a redirect always wins the PC
    assign pcWrite = issue || redirect;
    assign pcSrc   = redirect ? redirectSrc : PcNext;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            holdCnt <= 2'd0;
        else if (redirect)
            holdCnt <= (redirectSrc == PcJump) ? 2'(JumpHold) : 2'(BranchHold);
        else if (holdCnt != 2'd0)
            holdCnt <= holdCnt - 2'd1;
    end

endmodule

`default_nettype wire

/* src/instrSlot.sv */
`default_nettype none

module instrSlot (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     load,     // take entryIn this cycle
    input  wire ctrlPkg::slotEntry_t entryIn,
    input  wire                     grant,    // writeback done
    input  wire                     flush,
    output ctrlPkg::slotState_t     state,
    output ctrlPkg::slotEntry_t     entry
);
    import ctrlPkg::*;

    slotState_t nextState;

    ////////////////////////////////////////
    // per-class sequence
    ////////////////////////////////////////
    always_comb
    begin
        nextState = state;
        case (state)
            SlotIdle:
            begin
                if (load)
                    nextState = SlotDecode;
            end
            SlotDecode:
            begin
                // jump is done once it has redirected
                if (flush || entry.cls == ClsJump)
                    nextState = SlotIdle;
                else
                    nextState = SlotExecute;
            end
            SlotExecute:
            begin
                case (entry.cls)
                    ClsAlu, ClsImm:    nextState = SlotWbWait;
                    ClsLoad, ClsStore: nextState = SlotMem;
                    default:           nextState = SlotIdle;  // branch, nop
                endcase
            end
            SlotMem:
            begin
                if (entry.cls == ClsLoad)
                    nextState = SlotWbWait;
                else
                    nextState = SlotIdle;  // store ends here
            end
            SlotWbWait:
            begin
                if (grant)
                    nextState = SlotIdle;
            end
            default:
                nextState = SlotIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= SlotIdle;
        else
            state <= nextState;
    end

    // captured once per instruction
    always_ff @(posedge clk)
    begin
        if (load && state == SlotIdle)
            entry <= entryIn;
    end

endmodule

`default_nettype wire

/* src/slotPool.sv */
`default_nettype none

module slotPool #(
    parameter int NumSlots = 5
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     issue,
    input  wire ctrlPkg::slotEntry_t entry,
    output logic                    poolFull,
    poolIf.pool                     pool
);
    import ctrlPkg::*;

    logic [NumSlots-1:0] idleVec;
    logic [NumSlots-1:0] loadVec;  // one-hot target of this issue

    always_comb
    begin
        for (int i = 0; i < NumSlots; i++)
            idleVec[i] = (pool.slotState[i] == SlotIdle);
    end

    // lowest idle slot gets the new instruction
    assign loadVec  = issue ? (idleVec & (~idleVec + NumSlots'(1))) : '0;
    assign poolFull = ~|idleVec;

    ////////////////////////////////////////
    // slot array
    ////////////////////////////////////////
    for (genvar i = 0; i < NumSlots; i++)
    begin : gSlot
        instrSlot slotInst (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (loadVec[i]),
            .entryIn (entry),
            .grant   (pool.wbGrant[i]),
            .flush   (pool.flush),
            .state   (pool.slotState[i]),
            .entry   (pool.slotEntry[i])
        );
    end

endmodule

`default_nettype wire

/* src/retireCtrl.sv */
`default_nettype none

module retireCtrl #(
    parameter int NumSlots = 5
) (
    input  wire              aluZero,
    poolIf.retire            pool,
    output logic             memVisit,
    output logic             memWrite,
    output logic             regWrite,
    output ctrlPkg::regAddr_t wbAddr,
    output logic             memToReg,
    output logic             redirect,
    output ctrlPkg::pcSrc_t  redirectSrc
);
    import ctrlPkg::*;

    logic [NumSlots-1:0] wbReq;
    logic [NumSlots-1:0] grantVec;
    logic                branchTaken;
    logic                jumpDecode;

    ////////////////////////////////////////
    // writeback arbiter
    ////////////////////////////////////////
    always_comb
    begin
        for (int i = 0; i < NumSlots; i++)
            wbReq[i] = (pool.slotState[i] == SlotWbWait);
    end

    assign grantVec     = wbReq & (~wbReq + NumSlots'(1));  // lowest index wins
    assign pool.wbGrant = grantVec;
    assign regWrite     = |wbReq;

    always_comb
    begin
        wbAddr   = '0;
        memToReg = 1'b0;
        for (int i = 0; i < NumSlots; i++)
        begin
            if (grantVec[i])
            begin
                wbAddr   = pool.slotEntry[i].dest;
                memToReg = (pool.slotEntry[i].cls == ClsLoad);
            end
        end
    end

    ////////////////////////////////////////
    // data memory port
    ////////////////////////////////////////
    // issue cycles differ so at most one slot is in SlotMem
    always_comb
    begin
        memVisit = 1'b0;
        memWrite = 1'b0;
        for (int i = 0; i < NumSlots; i++)
        begin
            if (pool.slotState[i] == SlotMem)
            begin
                memVisit = 1'b1;
                if (pool.slotEntry[i].cls == ClsStore)
                    memWrite = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // redirect detection
    ////////////////////////////////////////
    always_comb
    begin
        branchTaken = 1'b0;
        jumpDecode  = 1'b0;
        for (int i = 0; i < NumSlots; i++)
        begin
            if (pool.slotState[i] == SlotExecute && pool.slotEntry[i].cls == ClsBranch)
                branchTaken = branchTaken | aluZero;  // beq compares in execute
            if (pool.slotState[i] == SlotDecode && pool.slotEntry[i].cls == ClsJump)
                jumpDecode = 1'b1;
        end
    end

    // older branch wins over the jump behind it
    assign redirect    = branchTaken || jumpDecode;
    assign redirectSrc = branchTaken ? PcBranch : (jumpDecode ? PcJump : PcNext);
    assign pool.flush  = redirect;

endmodule

`default_nettype wire

/* src/pipeCtrl.sv */
`default_nettype none

module pipeCtrl #(
    parameter int NumSlots = 5
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire ctrlPkg::instr_t instr,
    input  wire                 instrValid,
    input  wire                 aluZero,
    output logic                pcWrite,
    output ctrlPkg::pcSrc_t     pcSrc,
    output logic                memVisit,
    output logic                memWrite,
    output logic                regWrite,
    output ctrlPkg::regAddr_t   wbAddr,
    output logic                memToReg,
    output logic                flush
);
    import ctrlPkg::*;

    logic       issue;
    slotEntry_t entry;
    logic       poolFull;
    logic       redirect;
    pcSrc_t     redirectSrc;

    poolIf #(.NumSlots(NumSlots)) poolBus ();

    assign flush = poolBus.flush;

    ////////////////////////////////////////
    // stages
    ////////////////////////////////////////
    issueStage issueInst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instrValid  (instrValid),
        .poolFull    (poolFull),
        .memVisit    (memVisit),
        .redirect    (redirect),
        .redirectSrc (redirectSrc),
        .issue       (issue),
        .entry       (entry),
        .pcWrite     (pcWrite),
        .pcSrc       (pcSrc)
    );

    slotPool #(.NumSlots(NumSlots)) poolInst (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .entry    (entry),
        .poolFull (poolFull),
        .pool     (poolBus.pool)
    );

    retireCtrl #(.NumSlots(NumSlots)) retireInst (
        .aluZero     (aluZero),
        .pool        (poolBus.retire),
        .memVisit    (memVisit),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .wbAddr      (wbAddr),
        .memToReg    (memToReg),
        .redirect    (redirect),
        .redirectSrc (redirectSrc)
    );

endmodule

`default_nettype wire

/* tests/pipeCtrl_props.sv */
`default_nettype none

module pipeCtrlProps (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  pcWrite,
    input wire ctrlPkg::pcSrc_t pcSrc,
    input wire                  memVisit,
    input wire                  memWrite,
    input wire                  flush
);
    import ctrlPkg::*;

    ////////////////////////////////////////
    // port rules
    ////////////////////////////////////////
    flushRedirects: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> (pcWrite && pcSrc != PcNext))
        else $error("flush without a PC redirect");

    storeNeedsPort: assert property (@(posedge clk) disable iff (!rst_n)
        memWrite |-> memVisit)  // write only during an access
        else $error("memWrite outside a memory access");

    // memory cycle stalls issue
    noIssueOnMem: assert property (@(posedge clk) disable iff (!rst_n)
        memVisit |-> !(pcWrite && pcSrc == PcNext))
        else $error("issue while the memory port is busy");

endmodule

`default_nettype wire

/* tests/pipeCtrlTb.sv */
`default_nettype none

module pipeCtrlTb;
    import ctrlPkg::*;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 5;
    localparam int MaxLines    = 64;
    localparam int MaxCycles   = MaxLines * 12 + 32;
    localparam int JumpQuiet   = 2;   // no issue this long after a jump redirect
    localparam int BranchQuiet = 1;
    localparam int DrainCycles = 16;

    logic     clk;
    logic     rst_n;
    instr_t   instr;
    logic     instrValid;
    logic     aluZero;
    logic     pcWrite;
    pcSrc_t   pcSrc;
    logic     memVisit;
    logic     memWrite;
    logic     regWrite;
    regAddr_t wbAddr;
    logic     memToReg;
    logic     flush;

    instr_t      lineInstr [MaxLines];
    logic        lineZero  [MaxLines];
    regAddr_t    lineDest  [MaxLines];
    instrClass_t lineCls   [MaxLines];
    int          issueCyc  [MaxLines];
    logic        killed    [MaxLines];
    logic        retired   [MaxLines];
    logic        zeroPlan  [MaxCycles];  // aluZero per cycle
    int          numLines;
    logic        stimLoaded;
    int          cyc;
    int          idx;        // next line to issue
    int          holdUntil;
    int          lastIssue;

    pipeCtrl #(.NumSlots(5)) uut (
        .clk(clk), .rst_n(rst_n), .instr(instr), .instrValid(instrValid),
        .aluZero(aluZero), .pcWrite(pcWrite), .pcSrc(pcSrc), .memVisit(memVisit),
        .memWrite(memWrite), .regWrite(regWrite), .wbAddr(wbAddr),
        .memToReg(memToReg), .flush(flush)
    );

    bind pipeCtrl pipeCtrlProps propsInst (
        .clk(clk), .rst_n(rst_n), .pcWrite(pcWrite), .pcSrc(pcSrc),
        .memVisit(memVisit), .memWrite(memWrite), .flush(flush)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////
    task automatic stopOnError(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string name);
        if (actual !== expected)
            stopOnError($sformatf("FAIL at %0t: %s is %b, expected %b",
                $time, name, actual, expected));
    endtask

    task automatic checkAddr(input regAddr_t actual, input regAddr_t expected,
                             input string name);
        if (actual !== expected)
            stopOnError($sformatf("FAIL at %0t: %s is %0d, expected %0d",
                $time, name, actual, expected));
    endtask

    task automatic checkSrc(input pcSrc_t actual, input pcSrc_t expected, input string name);
        if (actual !== expected)
            stopOnError($sformatf("FAIL at %0t: %s is %s, expected %s",
                $time, name, actual.name(), expected.name()));
    endtask

    ////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////
    function automatic instrClass_t classOf(input instr_t word);
        case (word[31:26])
            6'd0:    return ClsAlu;
            6'd8:    return ClsImm;
            6'd35:   return ClsLoad;
            6'd43:   return ClsStore;
            6'd4:    return ClsBranch;
            6'd2:    return ClsJump;
            default: return ClsNop;
        endcase
    endfunction

    // live instruction still owing a register write
    function automatic logic owesWrite(input int k);
        return !killed[k] && !retired[k]
            && (lineCls[k] == ClsAlu || lineCls[k] == ClsImm || lineCls[k] == ClsLoad);
    endfunction

    function automatic int readyCycle(input int k);
        return issueCyc[k] + ((lineCls[k] == ClsLoad) ? 4 : 3);
    endfunction

    task automatic loadStimulus();
        int          fd;
        string       text;
        logic [31:0] word;
        logic [31:0] zero;
        logic [31:0] dest;
        numLines = 0;
        fd = $fopen("tests/pipeStimulus.txt", "r");
        if (fd == 0)
            stopOnError("cannot open tests/pipeStimulus.txt");
        while (!$feof(fd))
        begin
            text = "";
            void'($fgets(text, fd));
            if ($sscanf(text, "%h %h %h", word, zero, dest) == 3 && numLines < MaxLines)
            begin
                lineInstr[numLines] = word;
                lineZero[numLines]  = zero[0];
                lineDest[numLines]  = dest[4:0];
                lineCls[numLines]   = classOf(word);
                numLines++;
            end
        end
        $fclose(fd);
        if (numLines == 0)
            stopOnError("stimulus file holds no instruction lines");
    endtask

    task automatic checkQuiet();
        checkBit(pcWrite, 1'b0, "pcWrite");
        checkBit(flush, 1'b0, "flush");
        checkBit(memVisit, 1'b0, "memVisit");
        checkBit(memWrite, 1'b0, "memWrite");
        checkBit(regWrite, 1'b0, "regWrite");
    endtask

    // pairs this cycle's regWrite with a pending writer
    task automatic matchWriteback();
        int pick;
        int oldest;
        pick   = -1;
        oldest = -1;
        for (int k = 0; k < idx; k++)
        begin
            if (owesWrite(k) && cyc >= readyCycle(k))
            begin
                if (oldest < 0)
                    oldest = k;
                if (pick < 0 && lineDest[k] == wbAddr)
                    pick = k;
            end
        end
        if (pick < 0)
            pick = oldest;  // no address match so compare against the oldest
        checkAddr(wbAddr, lineDest[pick], "wbAddr");
        checkBit(memToReg, lineCls[pick] == ClsLoad, "memToReg");
        retired[pick] = 1'b1;
    endtask

    task automatic scoreCycle();
        logic expBranch;
        logic expJump;
        logic expMem;
        logic expStore;
        logic expWb;
        logic allowIssue;
        expBranch = 1'b0;
        expJump   = 1'b0;
        expMem    = 1'b0;
        expStore  = 1'b0;
        expWb     = 1'b0;
        for (int k = 0; k < idx; k++)
        begin
            if (!killed[k])
            begin
                if (lineCls[k] == ClsBranch && issueCyc[k] == cyc - 2 && lineZero[k])
                    expBranch = 1'b1;
                if (lineCls[k] == ClsJump && issueCyc[k] == cyc - 1)
                    expJump = 1'b1;
                if ((lineCls[k] == ClsLoad || lineCls[k] == ClsStore) && issueCyc[k] == cyc - 3)
                begin
                    expMem   = 1'b1;
                    expStore = (lineCls[k] == ClsStore);
                end
            end
            if (owesWrite(k) && cyc >= readyCycle(k))
                expWb = 1'b1;
        end
        checkBit(flush, expBranch || expJump, "flush");
        checkBit(memVisit, expMem, "memVisit");
        checkBit(memWrite, expStore, "memWrite");
        checkBit(regWrite, expWb, "regWrite");
        if (regWrite)
            matchWriteback();
        if (expBranch || expJump)
        begin
            checkBit(pcWrite, 1'b1, "pcWrite");
            checkSrc(pcSrc, expBranch ? PcBranch : PcJump, "pcSrc");
            for (int k = 0; k < idx; k++)
            begin
                if (issueCyc[k] == cyc - 1)
                    killed[k] = 1'b1;  // was in decode
            end
            holdUntil = cyc + (expBranch ? BranchQuiet : JumpQuiet);
        end
        else
        begin
            allowIssue = instrValid && !expMem && cyc > holdUntil;
            if (!allowIssue)
                checkBit(pcWrite, 1'b0, "pcWrite");
            if (pcWrite)
            begin
                checkSrc(pcSrc, PcNext, "pcSrc");
                issueCyc[idx] = cyc;
                killed[idx]   = 1'b0;
                retired[idx]  = 1'b0;
                if (lineCls[idx] == ClsBranch && cyc + 2 < MaxCycles)
                    zeroPlan[cyc + 2] = lineZero[idx];  // its execute cycle
                lastIssue = cyc;
                idx++;
            end
        end
    endtask

    function automatic int pendingWrites();
        int count;
        count = 0;
        for (int k = 0; k < idx; k++)
        begin
            if (owesWrite(k))
                count++;
        end
        return count;
    endfunction

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial
    begin
        rst_n      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        aluZero    = 1'b0;
        stimLoaded = 1'b0;
        cyc        = 0;
        idx        = 0;
        holdUntil  = -1;
        lastIssue  = 0;
        void'($urandom(81));
        for (int c = 0; c < MaxCycles; c++)
            zeroPlan[c] = 1'b0;
        loadStimulus();
        stimLoaded = 1'b1;
        repeat (ResetCycles)
        begin
            @(posedge clk);
            @(negedge clk);
            checkQuiet();
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkQuiet();  // nothing valid yet
        while (idx < numLines || cyc < lastIssue + DrainCycles)
        begin
            @(posedge clk);
            cyc++;
            if (idx < numLines)
                instr <= lineInstr[idx];
            instrValid <= (idx < numLines) && ($urandom_range(7, 0) != 0);
            aluZero    <= (cyc < MaxCycles) ? zeroPlan[cyc] : 1'b0;
            @(negedge clk);
            scoreCycle();
        end
        if (pendingWrites() != 0)
            stopOnError($sformatf("%0d writebacks never happened", pendingWrites()));
        else
        begin
            $display("PASS: all tests");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        wait (stimLoaded);
        #((numLines * 12 + ResetCycles) * ClkPeriod);
        stopOnError("timeout, the instruction stream did not drain");
    end

endmodule

`default_nettype wire

/* tests/pipeStimulus.txt */
# instruction word (hex), aluZero during the branch execute cycle,
# expected writeback register (hex, 00 for no write)
00221820 0 03
20050007 0 05
8C270000 0 07
AC470004 0 00
00854822 0 09
10220003 1 00
8C8A0008 0 0A
20A8FFFF 0 08
08000010 0 00
00696025 0 0C
1063FFFE 0 00
8C0D000C 0 0D
00468824 0 11
3C081234 0 00
10000005 1 00
08000040 0 00
20550010 0 15
AC290000 0 00
8CD90004 0 19
0023A02A 0 14
201E0001 0 1E
08000100 0 00
34420001 0 00
10220003 0 00
00221820 0 03
8C270000 0 07
20050007 0 05
10000005 1 00
AC470004 0 00
00854822 0 09

/* sources.f */
src/ctrlPkg.sv
src/poolIf.sv
src/issueStage.sv
src/instrSlot.sv
src/slotPool.sv
src/retireCtrl.sv
src/pipeCtrl.sv
tests/pipeCtrl_props.sv
tests/pipeCtrlTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pipeCtrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module pipeCtrlTb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VpipeCtrlTb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
echo "pass message not found"
exit 1
